// File: compile.f
+incdir+design
design/jtag_dma_pkg.sv
design/buffer_port_if.sv
design/dma_cmd_if.sv
design/jtag_chain_ctrl.sv
design/pingpong_buffer.sv
design/dma_bus_master.sv
design/jtag_support.sv
testbench/jtag_support_sva.sv
testbench/jtag_support_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= jtag_support_tb
RTL_TOP   ?= jtag_support
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  := Result: FAILED
PASS_MSG  := Result: PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation did not complete"; exit 1; fi

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: testbench/jtag_support_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "jtag_dma_consts.svh"

module jtag_support_tb;
    import jtag_dma_pkg::*;

    // Whole run takes under 3000 cycles
    localparam int TIMEOUT_CYCLES = 20000;
    localparam int WR_WORDS       = 16;
    localparam int RD_WORDS       = 12;

    logic  jtck;
    logic  rst_n;
    logic  jtdi;
    logic  jshift;
    logic  jupdate;
    logic  jce1;
    logic  jce2;
    logic  jrti1;
    logic  jrti2;
    logic  jtdo1;
    logic  jtdo2;
    word_t address_data_out;
    logic  [3:0] byte_enable;
    logic  [7:0] burst_size;
    logic  read_n_write;
    logic  begin_transaction;
    logic  end_transaction_out;
    logic  data_valid_out;
    word_t address_data_in;
    logic  end_transaction_in;
    logic  data_valid_in;
    logic  busy_in;
    logic  error_in;
    logic  request;
    logic  granted;

    // Bus slave model state
    word_t      slave_mem [256];
    word_t      beats [$];
    int         begin_count;
    int         end_out_count;
    word_t      seen_addr;
    logic [3:0] seen_be;
    logic [7:0] seen_size;
    logic       seen_rnw;
    logic       rd_active;
    int         rd_left;
    int         rd_index;
    int         grant_wait;
    logic       err_armed;

    integer     seed = 32'h38c0;
    int         cycle_count;
    int         mismatch_count;
    int         fail_count;
    logic       result_printed;
    word_t      wr_data [WR_WORDS];

    jtag_support dut_i (
        .jtck                (jtck),
        .rst_n               (rst_n),
        .jtdi                (jtdi),
        .jshift              (jshift),
        .jupdate             (jupdate),
        .jce1                (jce1),
        .jce2                (jce2),
        .jrti1               (jrti1),
        .jrti2               (jrti2),
        .jtdo1               (jtdo1),
        .jtdo2               (jtdo2),
        .address_data_out    (address_data_out),
        .byte_enable         (byte_enable),
        .burst_size          (burst_size),
        .read_n_write        (read_n_write),
        .begin_transaction   (begin_transaction),
        .end_transaction_out (end_transaction_out),
        .data_valid_out      (data_valid_out),
        .address_data_in     (address_data_in),
        .end_transaction_in  (end_transaction_in),
        .data_valid_in       (data_valid_in),
        .busy_in             (busy_in),
        .error_in            (error_in),
        .request             (request),
        .granted             (granted)
    );

    bind jtag_support jtag_support_sva sva_i (
        .jtck                (jtck),
        .rst_n               (rst_n),
        .jtdo1               (jtdo1),
        .jtdo2               (jtdo2),
        .address_data_out    (address_data_out),
        .begin_transaction   (begin_transaction),
        .end_transaction_out (end_transaction_out),
        .data_valid_out      (data_valid_out),
        .busy_in             (busy_in),
        .error_in            (error_in),
        .request             (request),
        .granted             (granted)
    );

    always #4 jtck = ~jtck;

    // Slave memory contents mix every address bit
    function automatic word_t mem_pattern(input int idx);
        word_t a;
        a = word_t'(idx);
        return 32'h5A00_0000 ^ (a * 32'h0101_0107) ^ (a << 20);
    endfunction

    task automatic step();
        @(posedge jtck);
        #1;
    endtask

    task automatic check_value(input string what, input word_t got, input word_t exp);
        assert (got === exp)
        else begin
            mismatch_count++;
            $display("Mismatch at time %0t: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input string what, input logic ok);
        assert (ok === 1'b1)
        else begin
            fail_count++;
            $display("Failure at time %0t: %s", $time, what);
        end
    endtask

    // LSB goes in first and jtdo is sampled before each shift edge
    task automatic shift_chain(input logic second, input logic [63:0] din, input int len,
                               output logic [63:0] dout);
        dout   = '0;
        jce1   = !second;
        jce2   = second;
        jshift = 1'b1;
        for (int i = 0; i < len; i++) begin
            jtdi    = din[i];
            dout[i] = second ? jtdo2 : jtdo1;
            step();
        end
        jshift = 1'b0;
        jtdi   = 1'b0;
        jce1   = 1'b0;
        jce2   = 1'b0;
    endtask

    task automatic pulse_update(input logic second);
        jce1    = !second;
        jce2    = second;
        jupdate = 1'b1;
        step();
        jupdate = 1'b0;
        jce1    = 1'b0;
        jce2    = 1'b0;
    endtask

    task automatic write_word(input buf_addr_t addr, input word_t data);
        logic [63:0] unused;
        shift_chain(1'b0, {22'b0, 1'b0, addr, data}, `CHAIN1_LEN, unused);
        pulse_update(1'b0);
    endtask

    task automatic read_word(input buf_addr_t addr, output word_t data);
        logic [63:0] dout;
        shift_chain(1'b0, {22'b0, 1'b0, addr, 32'h0}, `CHAIN1_LEN, dout);
        jrti1 = 1'b1;
        step();
        jrti1 = 1'b0;
        // Read data lands in the chain on this edge
        step();
        shift_chain(1'b0, 64'h0, `CHAIN1_LEN, dout);
        data = dout[31:0];
    endtask

    task automatic swap_banks();
        logic [63:0] unused;
        shift_chain(1'b0, {22'b0, 1'b1, 9'h0, 32'h0}, `CHAIN1_LEN, unused);
        pulse_update(1'b0);
        // Strobe cycle, then the select flips
        step();
        step();
    endtask

    task automatic send_command(input dma_cmd_t cmd);
        logic [63:0] unused;
        shift_chain(1'b1, {10'b0, cmd}, `CHAIN2_LEN, unused);
        pulse_update(1'b1);
    endtask

    task automatic read_status(output dma_status_t st);
        logic [63:0] dout;
        jrti2 = 1'b1;
        step();
        jrti2 = 1'b0;
        shift_chain(1'b1, 64'h0, `CHAIN2_LEN, dout);
        st = dma_status_t'(dout[2:0]);
    endtask

    // request drops on the same edge that clears busy
    task automatic wait_burst();
        while (!request) begin
            step();
        end
        while (request) begin
            step();
        end
    endtask

    // Arbiter, back-pressure, error injection and read data
    always @(posedge jtck) begin
        #1;
        if (!request) begin
            granted    = 1'b0;
            grant_wait = $random(seed) & 3;
        end else if (!granted) begin
            if (grant_wait == 0) begin
                granted = 1'b1;
            end else begin
                grant_wait--;
            end
        end
        busy_in  = (($random(seed) & 3) == 0);
        error_in = 1'b0;
        if (err_armed && data_valid_out && beats.size() >= 3) begin
            error_in  = 1'b1;
            err_armed = 1'b0;
        end
        data_valid_in      = 1'b0;
        end_transaction_in = 1'b0;
        if (rd_active && rd_left > 0 && ($random(seed) & 3) != 0) begin
            address_data_in    = slave_mem[rd_index];
            data_valid_in      = 1'b1;
            end_transaction_in = (rd_left == 1);
            rd_index++;
            rd_left--;
            if (rd_left == 0) begin
                rd_active = 1'b0;
            end
        end
    end

    // Bus monitor sampled mid-cycle
    always @(negedge jtck) begin
        if (rst_n) begin
            if (begin_transaction) begin
                begin_count++;
                seen_addr = address_data_out;
                seen_be   = byte_enable;
                seen_size = burst_size;
                seen_rnw  = read_n_write;
                if (read_n_write) begin
                    rd_active = 1'b1;
                    rd_index  = int'(address_data_out[9:2]);
                    rd_left   = int'(burst_size);
                end
            end
            if (data_valid_out && !busy_in) begin
                beats.push_back(address_data_out);
            end
            if (end_transaction_out) begin
                end_out_count++;
            end
        end
    end

    always @(posedge jtck) begin
        cycle_count++;
        if (cycle_count == TIMEOUT_CYCLES) begin
            fail_count++;
            result_printed = 1'b1;
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Errors: %0d mismatches, %0d other failures, %0d assertion failures",
                     mismatch_count, fail_count, dut_i.sva_i.error_count);
            $display("Result: FAILED");
            $finish;
        end
    end

    // Catches a run stopped early by the simulator
    final begin
        if (!result_printed) begin
            $display("Result: FAILED");
        end
    end

    initial begin
        word_t       got;
        dma_cmd_t    cmd;
        dma_status_t st;

        jtck               = 1'b0;
        rst_n              = 1'b0;
        jtdi               = 1'b0;
        jshift             = 1'b0;
        jupdate            = 1'b0;
        jce1               = 1'b0;
        jce2               = 1'b0;
        jrti1              = 1'b0;
        jrti2              = 1'b0;
        address_data_in    = '0;
        end_transaction_in = 1'b0;
        data_valid_in      = 1'b0;
        busy_in            = 1'b0;
        error_in           = 1'b0;
        granted            = 1'b0;
        rd_active          = 1'b0;
        rd_left            = 0;
        rd_index           = 0;
        grant_wait         = 0;
        err_armed          = 1'b0;
        begin_count        = 0;
        end_out_count      = 0;
        cycle_count        = 0;
        mismatch_count     = 0;
        fail_count         = 0;
        result_printed     = 1'b0;
        for (int i = 0; i < 256; i++) begin
            slave_mem[i] = mem_pattern(i);
        end
        for (int i = 0; i < WR_WORDS; i++) begin
            wr_data[i] = $random(seed);
        end

        repeat (5) @(posedge jtck);
        #1;
        rst_n = 1'b1;
        step();

        // Single words through chain 1
        for (int i = 0; i < 4; i++) begin
            write_word(buf_addr_t'(3 + i * 37), ~wr_data[i]);
        end
        for (int i = 0; i < 4; i++) begin
            read_word(buf_addr_t'(3 + i * 37), got);
            check_value("chain 1 read-back", got, ~wr_data[i]);
        end

        // Fill, swap, then a write burst out of the DMA bank
        for (int i = 0; i < WR_WORDS; i++) begin
            write_word(buf_addr_t'(16 + i), wr_data[i]);
        end
        swap_banks();
        beats.delete();
        begin_count   = 0;
        end_out_count = 0;
        cmd = '{bus_addr: 32'h0000_0400, byte_enable: 4'b1011, burst_size: 8'(WR_WORDS),
                read_n_write: 1'b0, buf_start: 9'd16};
        send_command(cmd);
        wait_burst();
        check_value("write begin count", begin_count, 1);
        check_value("write bus address", seen_addr, cmd.bus_addr);
        check_value("write byte enable", seen_be, cmd.byte_enable);
        check_value("write burst size", seen_size, cmd.burst_size);
        check_value("write direction", seen_rnw, 1'b0);
        check_value("write beat count", beats.size(), WR_WORDS);
        check_value("write end count", end_out_count, 1);
        for (int i = 0; i < WR_WORDS && i < beats.size(); i++) begin
            check_value("write beat data", beats[i], wr_data[i]);
        end
        read_status(st);
        check_value("status after write burst", st, 3'b010);

        // Read burst into the DMA bank, then swap it over to JTAG
        beats.delete();
        begin_count = 0;
        cmd = '{bus_addr: 32'h0000_0100, byte_enable: 4'hF, burst_size: 8'(RD_WORDS),
                read_n_write: 1'b1, buf_start: 9'd200};
        send_command(cmd);
        wait_burst();
        check_value("read begin count", begin_count, 1);
        read_status(st);
        check_value("status after read burst", st, 3'b010);
        swap_banks();
        for (int i = 0; i < RD_WORDS; i++) begin
            read_word(buf_addr_t'(200 + i), got);
            check_value("DMA read word", got, mem_pattern(64 + i));
        end

        // Bus error in the middle of a write burst
        beats.delete();
        err_armed = 1'b1;
        cmd = '{bus_addr: 32'h0000_0800, byte_enable: 4'hF, burst_size: 8'd8,
                read_n_write: 1'b0, buf_start: 9'd0};
        send_command(cmd);
        wait_burst();
        check_flag("bus error was never injected", !err_armed);
        read_status(st);
        check_value("status after bus error", st, 3'b001);

        repeat (4) step();
        result_printed = 1'b1;
        $display("Errors: %0d mismatches, %0d other failures, %0d assertion failures",
                 mismatch_count, fail_count, dut_i.sva_i.error_count);
        if (mismatch_count == 0 && fail_count == 0 && dut_i.sva_i.error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/jtag_support_sva.sv
`timescale 1ns/10ps
`default_nettype none

module jtag_support_sva (
    input wire logic                jtck,
    input wire logic                rst_n,
    input wire logic                jtdo1,
    input wire logic                jtdo2,
    input wire jtag_dma_pkg::word_t address_data_out,
    input wire logic                begin_transaction,
    input wire logic                end_transaction_out,
    input wire logic                data_valid_out,
    input wire logic                busy_in,
    input wire logic                error_in,
    input wire logic                request,
    input wire logic                granted
);

    // Assertion failures so far
    int error_count = 0;

    // Quiet outputs on the cycle after a reset edge
    reset_quiet: assert property (@(posedge jtck)
        !rst_n |=> !(request || begin_transaction || end_transaction_out ||
                     data_valid_out || jtdo1 || jtdo2))
        else begin
            $error("Control output high after reset");
            error_count++;
        end

    // Address phase no later than the cycle after the grant arrives
    begin_granted: assert property (@(posedge jtck) disable iff (!rst_n)
        $rose(granted) |-> ##[0:1] begin_transaction)
        else begin
            $error("Grant without a prompt address phase");
            error_count++;
        end

    // Bus owned for the whole burst
    request_held: assert property (@(posedge jtck) disable iff (!rst_n)
        (begin_transaction || data_valid_out || end_transaction_out) |-> request)
        else begin
            $error("Burst activity without request");
            error_count++;
        end

    // A stalled beat stays on the bus unchanged
    beat_held: assert property (@(posedge jtck) disable iff (!rst_n)
        (data_valid_out && busy_in && !error_in) |=>
            (data_valid_out && $stable(address_data_out)))
        else begin
            $error("Write beat changed under back-pressure");
            error_count++;
        end

    begin_single: assert property (@(posedge jtck) disable iff (!rst_n)
        begin_transaction |=> !begin_transaction)
        else begin
            $error("Address phase longer than one cycle");
            error_count++;
        end

    end_single: assert property (@(posedge jtck) disable iff (!rst_n)
        end_transaction_out |=> !end_transaction_out)
        else begin
            $error("End of burst longer than one cycle");
            error_count++;
        end

    end_after_beats: assert property (@(posedge jtck) disable iff (!rst_n)
        end_transaction_out |-> !data_valid_out)
        else begin
            $error("Write beat together with end of burst");
            error_count++;
        end

endmodule

`default_nettype wire

// File: design/jtag_support.sv
`timescale 1ns/10ps
`default_nettype none

module jtag_support (
    // JTAG side
    input  wire logic                jtck,
    input  wire logic                rst_n,
    input  wire logic                jtdi,
    input  wire logic                jshift,
    input  wire logic                jupdate,
    input  wire logic                jce1,
    input  wire logic                jce2,
    input  wire logic                jrti1,
    input  wire logic                jrti2,
    output wire logic                jtdo1,
    output wire logic                jtdo2,

    // Shared bus
    output wire jtag_dma_pkg::word_t address_data_out,
    output wire logic [3:0]          byte_enable,
    output wire logic [7:0]          burst_size,
    output wire logic                read_n_write,
    output wire logic                begin_transaction,
    output wire logic                end_transaction_out,
    output wire logic                data_valid_out,
    input  wire jtag_dma_pkg::word_t address_data_in,
    input  wire logic                end_transaction_in,
    input  wire logic                data_valid_in,
    input  wire logic                busy_in,
    input  wire logic                error_in,

    // Arbiter
    output wire logic                request,
    input  wire logic                granted
);

    buffer_port_if port_a ();
    buffer_port_if port_b ();
    dma_cmd_if     dma ();

    wire logic bank_swap;

    jtag_chain_ctrl chain_ctrl_i (
        .jtck      (jtck),
        .rst_n     (rst_n),
        .jtdi      (jtdi),
        .jshift    (jshift),
        .jupdate   (jupdate),
        .jce1      (jce1),
        .jce2      (jce2),
        .jrti1     (jrti1),
        .jrti2     (jrti2),
        .jtdo1     (jtdo1),
        .jtdo2     (jtdo2),
        .port_a    (port_a.user),
        .bank_swap (bank_swap),
        .dma       (dma.issuer)
    );

    pingpong_buffer buffer_i (
        .jtck      (jtck),
        .rst_n     (rst_n),
        .port_a    (port_a.mem),
        .port_b    (port_b.mem),
        .bank_swap (bank_swap)
    );

    dma_bus_master dma_master_i (
        .jtck                (jtck),
        .rst_n               (rst_n),
        .dma                 (dma.engine),
        .port_b              (port_b.user),
        .address_data_out    (address_data_out),
        .byte_enable         (byte_enable),
        .burst_size          (burst_size),
        .read_n_write        (read_n_write),
        .begin_transaction   (begin_transaction),
        .end_transaction_out (end_transaction_out),
        .data_valid_out      (data_valid_out),
        .address_data_in     (address_data_in),
        .end_transaction_in  (end_transaction_in),
        .data_valid_in       (data_valid_in),
        .busy_in             (busy_in),
        .error_in            (error_in),
        .request             (request),
        .granted             (granted)
    );

endmodule

`default_nettype wire

// File: design/dma_bus_master.sv
`timescale 1ns/10ps
`default_nettype none

module dma_bus_master (
    input  wire logic                 jtck,
    input  wire logic                 rst_n,
    dma_cmd_if.engine                 dma,
    buffer_port_if.user               port_b,
    output jtag_dma_pkg::word_t       address_data_out,
    output logic [3:0]                byte_enable,
    output logic [7:0]                burst_size,
    output logic                      read_n_write,
    output logic                      begin_transaction,
    output logic                      end_transaction_out,
    output logic                      data_valid_out,
    input  wire jtag_dma_pkg::word_t  address_data_in,
    input  wire logic                 end_transaction_in,
    input  wire logic                 data_valid_in,
    input  wire logic                 busy_in,
    input  wire logic                 error_in,
    output logic                      request,
    input  wire logic                 granted
);
    import jtag_dma_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_REQ,
        S_BEGIN,
        S_WRITE,
        S_READ,
        S_END
    } state_t;

    state_t     state;
    dma_cmd_t   cmd_q;
    logic [7:0] beat_cnt;
    buf_addr_t  buf_addr;
    logic       done_q;
    logic       error_q;
    logic       accept;
    logic       prefetch;

    assign accept = (state == S_IDLE) && dma.start;

    // Address phase on the first granted cycle after the request
    assign begin_transaction = (state == S_BEGIN) && granted;

    assign byte_enable  = cmd_q.byte_enable;
    assign burst_size   = cmd_q.burst_size;
    assign read_n_write = cmd_q.read_n_write;

    // Word in rdata moves onto the bus, fetch the one after it
    assign prefetch = (begin_transaction && !cmd_q.read_n_write) ||
                      (state == S_WRITE && !busy_in && beat_cnt != 8'd0);

    // buf_addr always names the word sitting in rdata during writes
    assign port_b.addr         = prefetch ? buf_addr + 1'b1 : buf_addr;
    assign port_b.write_enable = (state == S_READ) && data_valid_in;
    assign port_b.wdata        = address_data_in;

    assign dma.status = '{busy: (state != S_IDLE), done: done_q, error: error_q};

    always_ff @(posedge jtck) begin
        if (!rst_n) begin
            state               <= S_IDLE;
            request             <= 1'b0;
            end_transaction_out <= 1'b0;
            data_valid_out      <= 1'b0;
            done_q              <= 1'b0;
            error_q             <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (dma.start) begin
                        done_q  <= 1'b0;
                        error_q <= 1'b0;
                        request <= 1'b1;
                        state   <= S_REQ;
                    end
                end
                // First buffer word is being fetched here
                S_REQ: begin
                    state <= S_BEGIN;
                end
                S_BEGIN: begin
                    if (granted) begin
                        if (cmd_q.read_n_write) begin
                            state <= S_READ;
                        end else begin
                            data_valid_out <= 1'b1;
                            state          <= S_WRITE;
                        end
                    end
                end
                S_WRITE: begin
                    if (error_in) begin
                        request        <= 1'b0;
                        data_valid_out <= 1'b0;
                        error_q        <= 1'b1;
                        state          <= S_IDLE;
                    end else if (!busy_in && beat_cnt == 8'd0) begin
                        data_valid_out      <= 1'b0;
                        end_transaction_out <= 1'b1;
                        state               <= S_END;
                    end
                end
                S_READ: begin
                    if (error_in) begin
                        request <= 1'b0;
                        error_q <= 1'b1;
                        state   <= S_IDLE;
                    end else if (end_transaction_in) begin
                        request <= 1'b0;
                        done_q  <= 1'b1;
                        state   <= S_IDLE;
                    end
                end
                S_END: begin
                    end_transaction_out <= 1'b0;
                    request             <= 1'b0;
                    done_q              <= 1'b1;
                    state               <= S_IDLE;
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // Command, counters and bus word
    always_ff @(posedge jtck) begin
        if (accept) begin
            cmd_q            <= dma.cmd;
            address_data_out <= dma.cmd.bus_addr;
            buf_addr         <= dma.cmd.buf_start;
        end else begin
            if (prefetch || port_b.write_enable) begin
                buf_addr <= buf_addr + 1'b1;
            end
            // Counts beats still to go after the one on the bus
            if (begin_transaction) begin
                beat_cnt <= cmd_q.burst_size - 8'd1;
            end else if (prefetch) begin
                beat_cnt <= beat_cnt - 8'd1;
            end
            if (prefetch) begin
                address_data_out <= port_b.rdata;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/pingpong_buffer.sv
`timescale 1ns/10ps
`default_nettype none

`include "jtag_dma_consts.svh"

module pingpong_buffer (
    input  wire logic  jtck,
    input  wire logic  rst_n,
    buffer_port_if.mem port_a,
    buffer_port_if.mem port_b,
    input  wire logic  bank_swap
);
    import jtag_dma_pkg::*;

    word_t     bank0 [`BUF_DEPTH];
    word_t     bank1 [`BUF_DEPTH];
    logic      bank_sel;
    logic      sel_q;
    buf_addr_t addr0;
    buf_addr_t addr1;
    logic      we0;
    logic      we1;
    word_t     wdata0;
    word_t     wdata1;
    word_t     rd0;
    word_t     rd1;

    // Port A owns the selected bank, port B the other one
    assign addr0  = bank_sel ? port_b.addr : port_a.addr;
    assign we0    = bank_sel ? port_b.write_enable : port_a.write_enable;
    assign wdata0 = bank_sel ? port_b.wdata : port_a.wdata;
    assign addr1  = bank_sel ? port_a.addr : port_b.addr;
    assign we1    = bank_sel ? port_a.write_enable : port_b.write_enable;
    assign wdata1 = bank_sel ? port_a.wdata : port_b.wdata;

    always_ff @(posedge jtck) begin
        if (!rst_n) begin
            bank_sel <= 1'b0;
            sel_q    <= 1'b0;
        end else begin
            if (bank_swap) begin
                bank_sel <= ~bank_sel;
            end
            // Remember which bank each read went to
            sel_q <= bank_sel;
        end
    end

    always_ff @(posedge jtck) begin
        if (we0) begin
            bank0[addr0] <= wdata0;
        end
        if (we1) begin
            bank1[addr1] <= wdata1;
        end
        rd0 <= bank0[addr0];
        rd1 <= bank1[addr1];
    end

    assign port_a.rdata = sel_q ? rd1 : rd0;
    assign port_b.rdata = sel_q ? rd0 : rd1;

endmodule

`default_nettype wire

// File: design/jtag_chain_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

`include "jtag_dma_consts.svh"

module jtag_chain_ctrl (
    input  wire logic   jtck,
    input  wire logic   rst_n,
    input  wire logic   jtdi,
    input  wire logic   jshift,
    input  wire logic   jupdate,
    input  wire logic   jce1,
    input  wire logic   jce2,
    input  wire logic   jrti1,
    input  wire logic   jrti2,
    output logic        jtdo1,
    output logic        jtdo2,
    buffer_port_if.user port_a,
    output logic        bank_swap,
    dma_cmd_if.issuer   dma
);
    import jtag_dma_pkg::*;

    logic [`CHAIN1_LEN-1:0] chain1;
    logic [`CHAIN2_LEN-1:0] chain2;
    logic                   last_ce2;
    logic                   rd_pend;
    logic                   upd1;
    logic                   upd2;
    logic                   swap_flag;

    // Update acts on the chain enabled now, else on the last one shifted
    assign upd2 = jupdate && (jce2 || (!jce1 && last_ce2));
    assign upd1 = jupdate && (jce1 || (!jce2 && !last_ce2));

    assign swap_flag = chain1[`CH1_SWAP_BIT];

    assign jtdo1 = chain1[0];
    assign jtdo2 = chain2[0];

    // Buffer write goes out on the update edge itself
    assign port_a.addr         = chain1[`CH1_ADDR_LSB +: $bits(buf_addr_t)];
    assign port_a.wdata        = chain1[`CH1_DATA_LSB +: $bits(word_t)];
    assign port_a.write_enable = upd1 && !swap_flag;

    always_ff @(posedge jtck) begin
        if (!rst_n) begin
            last_ce2 <= 1'b0;
            rd_pend  <= 1'b0;
        end else begin
            if (jce1 || jce2) begin
                last_ce2 <= jce2;
            end
            // Read data shows up one cycle after the address
            rd_pend <= jrti1;
        end
    end

    always_ff @(posedge jtck) begin
        if (!rst_n) begin
            chain1 <= '0;
        end else if (jshift && jce1) begin
            chain1 <= {jtdi, chain1[`CHAIN1_LEN-1:1]};
        end else if (rd_pend) begin
            chain1[`CH1_DATA_LSB +: $bits(word_t)] <= port_a.rdata;
        end
    end

    always_ff @(posedge jtck) begin
        if (!rst_n) begin
            chain2 <= '0;
        end else if (jshift && jce2) begin
            chain2 <= {jtdi, chain2[`CHAIN2_LEN-1:1]};
        end else if (jrti2) begin
            chain2[`CH2_STATUS_LSB +: $bits(dma_status_t)] <= dma.status;
        end
    end

    // One-cycle strobes out of the update edge
    always_ff @(posedge jtck) begin
        if (!rst_n) begin
            bank_swap <= 1'b0;
            dma.start <= 1'b0;
        end else begin
            bank_swap <= upd1 && swap_flag;
            dma.start <= upd2;
        end
    end

    always_ff @(posedge jtck) begin
        if (upd2) begin
            dma.cmd <= dma_cmd_t'(chain2);
        end
    end

endmodule

`default_nettype wire

// File: design/dma_cmd_if.sv
`timescale 1ns/10ps
`default_nettype none

interface dma_cmd_if;
    import jtag_dma_pkg::*;

    dma_cmd_t    cmd;
    // One-cycle pulse, dropped by the engine while busy
    logic        start;
    dma_status_t status;

    modport issuer (
        output cmd, start,
        input  status
    );

    modport engine (
        input  cmd, start,
        output status
    );

endinterface

`default_nettype wire

// File: design/buffer_port_if.sv
`timescale 1ns/10ps
`default_nettype none

interface buffer_port_if;
    import jtag_dma_pkg::*;

    buf_addr_t addr;
    logic      write_enable;
    word_t     wdata;
    // Registered, valid one cycle after addr
    word_t     rdata;

    modport user (
        output addr, write_enable, wdata,
        input  rdata
    );

    modport mem (
        input  addr, write_enable, wdata,
        output rdata
    );

endinterface

`default_nettype wire

// File: design/jtag_dma_pkg.sv
`default_nettype none

`include "jtag_dma_consts.svh"

package jtag_dma_pkg;

    // Bus and buffer word
    typedef logic [31:0] word_t;

    // Word address inside one bank
    typedef logic [$clog2(`BUF_DEPTH)-1:0] buf_addr_t;

    // DMA command, MSB first as shifted into chain 2
    typedef struct packed {
        word_t      bus_addr;
        logic [3:0] byte_enable;
        logic [7:0] burst_size;
        logic       read_n_write;
        buf_addr_t  buf_start;
    } dma_cmd_t;

    // Engine status; done and error stay set until the next start
    typedef struct packed {
        logic busy;
        logic done;
        logic error;
    } dma_status_t;

endpackage

`default_nettype wire

// File: design/jtag_dma_consts.svh
`ifndef JTAG_DMA_CONSTS_SVH
`define JTAG_DMA_CONSTS_SVH

// Words in each ping-pong bank
`define BUF_DEPTH 512

// Chain 1 layout: data word, buffer address, swap flag at the top
`define CHAIN1_LEN   42
`define CH1_DATA_LSB 0
`define CH1_ADDR_LSB 32
`define CH1_SWAP_BIT 41

// Chain 2 holds a dma_cmd_t
`define CHAIN2_LEN 54

// Status lands in the low bits of chain 2 on capture
`define CH2_STATUS_LSB 0

`endif
